/* runSim.sh */
#!/bin/sh
# build the sigmoid testbench with Verilator and run it
# the result is taken from the log, a failed build counts as a failed run

LOG=sim.log
SIM=obj_dir/sigmoidSim

rm -f "$LOG"

verilator --binary --timescale 1ns/10ps --top-module sigmoidTb \
	-f sigmoid.f -o sigmoidSim \
	&& "$SIM" > "$LOG" 2>&1 \
	|| echo "CHECKS FAILED" >> "$LOG"

cat "$LOG"

grep -qx "CHECKS FAILED" "$LOG" && exit 1
exit 0

/* sigmoid.f */
+incdir+.
sigmoidTypesPkg.sv
sigmoidCoefPkg.sv
sigmoidSideIf.sv
sigmoidAbsSegment.sv
sigmoidSlopeMul.sv
sigmoidOutputStage.sv
sigmoid.sv
sigmoidTb.sv

/* sigmoid.sv */
`timescale 1ns/10ps
`default_nettype none

module sigmoid (
	input  logic                   clk,
	input  logic                   i_rstN,
	input  logic                   i_inValid,
	input  sigmoidTypesPkg::xData  i_x,
	output sigmoidTypesPkg::yData  o_y,
	output logic                   o_outValid
);

	import sigmoidTypesPkg::*;

	slopeVal slope;
	fracData frac;
	prodVal  prod;
	icptVal  icpt;

	sigmoidSideIf sideA ();
	sigmoidSideIf sideB ();

	// stages 0-1
	sigmoidAbsSegment uAbsSeg (
		.clk       (clk),
		.i_rstN    (i_rstN),
		.i_inValid (i_inValid),
		.i_x       (i_x),
		.side      (sideA.source),
		.o_slope   (slope),
		.o_frac    (frac)
	);

	// stages 2-3
	sigmoidSlopeMul uSlopeMul (
		.clk     (clk),
		.i_rstN  (i_rstN),
		.sideIn  (sideA.sink),
		.sideOut (sideB.source),
		.i_slope (slope),
		.i_frac  (frac),
		.o_prod  (prod),
		.o_icpt  (icpt)
	);

	// stages 4-5
	sigmoidOutputStage uOut (
		.clk        (clk),
		.i_rstN     (i_rstN),
		.side       (sideB.sink),
		.i_prod     (prod),
		.i_icpt     (icpt),
		.o_y        (o_y),
		.o_outValid (o_outValid)
	);

endmodule

`default_nettype wire

/* sigmoidAbsSegment.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sigmoid_config.svh"

module sigmoidAbsSegment (
	input  logic                      clk,
	input  logic                      i_rstN,
	input  logic                      i_inValid,
	input  sigmoidTypesPkg::xData     i_x,
	sigmoidSideIf.source              side,
	output sigmoidTypesPkg::slopeVal  o_slope,
	output sigmoidTypesPkg::fracData  o_frac
);

	import sigmoidTypesPkg::*;
	import sigmoidCoefPkg::*;

	xData   xNeg;
	logic   validQ;
	xData   xQ;
	xData   xNegQ;
	logic   sign;
	absData absX;
	logic   special;
	segIdx  seg;

	// two's complement negation
	assign xNeg = -i_x;

	// stage 0
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			validQ <= 1'b0;
			xQ     <= '0;
			xNegQ  <= '0;
		end else begin
			validQ <= i_inValid;
			xQ     <= i_x;
			xNegQ  <= xNeg;
		end
	end

	assign sign = xQ[`SIG_X_W-1];
	assign absX = sign ? absData'(xNegQ) : absData'(xQ);

	// -128 negates to itself, so the magnitude keeps bit 7
	assign special = sign & absX[`SIG_X_W-1];

	// segment from magnitude bits 6..4
	assign seg = absX[`SIG_FRAC_W +: `SIG_SEG_W];

	// stage 1
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			side.valid   <= 1'b0;
			side.sign    <= 1'b0;
			side.special <= 1'b0;
			side.seg     <= '0;
			o_slope      <= '0;
			o_frac       <= '0;
		end else begin
			side.valid   <= validQ;
			side.sign    <= sign;
			side.special <= special;
			side.seg     <= seg;
			o_slope      <= slopeTable[seg];
			o_frac       <= absX[`SIG_FRAC_W-1:0];
		end
	end

endmodule

`default_nettype wire

/* sigmoidCoefPkg.sv */
`default_nettype none

`include "sigmoid_config.svh"

package sigmoidCoefPkg;

	import sigmoidTypesPkg::*;

	// slope per segment, scaled by 2^-6
	localparam slopeVal slopeTable [`SIG_SEG_NUM] = '{
		4'd15,
		4'd14,
		4'd11,
		4'd8,
		4'd6,
		4'd4,
		4'd2,
		4'd1
	};

	// intercept per segment, scaled by 2^-11
	localparam icptVal icptTable [`SIG_SEG_NUM] = '{
		10'd3,
		10'd253,
		10'd478,
		10'd655,
		10'd779,
		10'd868,
		10'd930,
		10'd968
	};

endpackage

`default_nettype wire

/* sigmoidOutputStage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sigmoid_config.svh"

module sigmoidOutputStage (
	input  logic                     clk,
	input  logic                     i_rstN,
	sigmoidSideIf.sink               side,
	input  sigmoidTypesPkg::prodVal  i_prod,
	input  sigmoidTypesPkg::icptVal  i_icpt,
	output sigmoidTypesPkg::yData    o_y,
	output logic                     o_outValid
);

	import sigmoidTypesPkg::*;

	// fixed code returned for x = -128
	localparam yData specialY = 16'h024D;

	icptVal func;
	icptVal funcQ;
	logic   validQ;
	logic   signQ;
	logic   specialQ;
	yData   yEnc;

	// intercept add, wraps at 1024
	assign func = icptVal'(i_prod) + i_icpt;

	// stage 4
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			validQ   <= 1'b0;
			signQ    <= 1'b0;
			specialQ <= 1'b0;
			funcQ    <= '0;
		end else begin
			validQ   <= side.valid;
			signQ    <= side.sign;
			specialQ <= side.special;
			funcQ    <= func;
		end
	end

	// negative inputs give 1 - f, stored as the inverted field
	assign yEnc = specialQ ? specialY
		: {1'b0, ~signQ, funcQ ^ {`SIG_ICPT_W{signQ}}, signQ, 3'b011};

	// stage 5
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			o_outValid <= 1'b0;
			o_y        <= '0;
		end else begin
			o_outValid <= validQ;
			o_y        <= yEnc;
		end
	end

endmodule

`default_nettype wire

/* sigmoidSideIf.sv */
`timescale 1ns/10ps
`default_nettype none

// sideband that travels next to the data words between stages
interface sigmoidSideIf;

	import sigmoidTypesPkg::*;

	logic  valid;
	logic  sign;
	logic  special;
	segIdx seg;

	modport source (
		output valid,
		output sign,
		output special,
		output seg
	);

	modport sink (
		input valid,
		input sign,
		input special,
		input seg
	);

endinterface

`default_nettype wire

/* sigmoidSlopeMul.sv */
`timescale 1ns/10ps
`default_nettype none

module sigmoidSlopeMul (
	input  logic                      clk,
	input  logic                      i_rstN,
	sigmoidSideIf.sink                sideIn,
	sigmoidSideIf.source              sideOut,
	input  sigmoidTypesPkg::slopeVal  i_slope,
	input  sigmoidTypesPkg::fracData  i_frac,
	output sigmoidTypesPkg::prodVal   o_prod,
	output sigmoidTypesPkg::icptVal   o_icpt
);

	import sigmoidTypesPkg::*;
	import sigmoidCoefPkg::*;

	partSum sumLow;
	partSum sumHigh;
	partSum sumLowQ;
	partSum sumHighQ;
	logic   validQ;
	logic   signQ;
	logic   specialQ;
	segIdx  segQ;
	prodVal prod;

	// slope bits 0/1 and bits 2/3 as two shifted-add pairs
	assign sumLow = (i_slope[0] ? partSum'(i_frac) : '0)
		+ (i_slope[1] ? partSum'({i_frac, 1'b0}) : '0);
	assign sumHigh = (i_slope[2] ? partSum'(i_frac) : '0)
		+ (i_slope[3] ? partSum'({i_frac, 1'b0}) : '0);

	// stage 2
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			validQ   <= 1'b0;
			signQ    <= 1'b0;
			specialQ <= 1'b0;
			segQ     <= '0;
			sumLowQ  <= '0;
			sumHighQ <= '0;
		end else begin
			validQ   <= sideIn.valid;
			signQ    <= sideIn.sign;
			specialQ <= sideIn.special;
			segQ     <= sideIn.seg;
			sumLowQ  <= sumLow;
			sumHighQ <= sumHigh;
		end
	end

	// upper pair carries weight 4
	assign prod = prodVal'(sumLowQ) + (prodVal'(sumHighQ) << 2);

	// stage 3
	always_ff @(posedge clk) begin
		if (!i_rstN) begin
			sideOut.valid   <= 1'b0;
			sideOut.sign    <= 1'b0;
			sideOut.special <= 1'b0;
			sideOut.seg     <= '0;
			o_prod          <= '0;
			o_icpt          <= '0;
		end else begin
			sideOut.valid   <= validQ;
			sideOut.sign    <= signQ;
			sideOut.special <= specialQ;
			sideOut.seg     <= segQ;
			o_prod          <= prod;
			o_icpt          <= icptTable[segQ];
		end
	end

endmodule

`default_nettype wire

/* sigmoidTbVectors.svh */
`ifndef SIGMOID_TB_VECTORS_SVH
`define SIGMOID_TB_VECTORS_SVH

// stimulus table for the sigmoid testbench, included inside the testbench module
// each entry holds one x and the y expected for it

localparam int numVectors = 24;

// positive inputs first, covering segments 0 to 7 and the top of the range
// then negative inputs, covering the same segments plus -1, -127 and -128
localparam int xList [numVectors] = '{
	0,
	5,
	1,
	17,
	38,
	52,
	63,
	71,
	90,
	100,
	113,
	127,
	-1,
	-2,
	-20,
	-33,
	-55,
	-64,
	-80,
	-99,
	-112,
	-120,
	-127,
	-128
};

xData xTab [numVectors];
yData yTab [numVectors];

// expected result from the segment tables and the output encoding
function automatic yData refSigmoid(input xData x);
	int      mag;
	int      f;
	logic    neg;
	segIdx   seg;
	fracData frac;
	icptVal  field;
	yData    y;
	neg = (x < 0);
	mag = neg ? -int'(x) : int'(x);
	seg = segIdx'(mag / 16);
	frac = fracData'(mag % 16);
	// a * frac + b, wrapping at 1024
	f = (int'(slopeTable[seg]) * int'(frac) + int'(icptTable[seg])) % 1024;
	field = icptVal'(f);
	// negative side returns 1 - f as the inverted field
	if (neg) begin
		field = ~field;
	end
	y = '0;
	y[14] = ~neg;
	y[13:4] = field;
	y[3] = neg;
	y[2:0] = 3'b011;
	// -128 has no positive counterpart
	if (mag == 128) begin
		y = 16'h024D;
	end
	return y;
endfunction

// fill the table at time 0
task automatic fillTable();
	for (int i = 0; i < numVectors; i++) begin
		xTab[i] = xData'(xList[i]);
		yTab[i] = refSigmoid(xTab[i]);
	end
endtask

`endif

/* sigmoidTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sigmoid_config.svh"

module sigmoidTb;

	import sigmoidTypesPkg::*;
	import sigmoidCoefPkg::*;

	`include "sigmoidTbVectors.svh"

	// longest wait for the pipeline to drain, in clocks
	localparam int drainLimit = 4 * `SIG_LATENCY;

	localparam logic [16:0] lfsrSeed = 17'd92332;

	logic clk;
	logic i_rstN;
	logic i_inValid;
	xData i_x;
	yData o_y;
	logic o_outValid;

	// results still in flight, oldest first
	yData expY [$];
	xData expX [$];

	// valid as sampled by the DUT on each rising edge, newest in bit 0
	logic [`SIG_LATENCY-1:0] validHist;
	logic                    resetDone;
	logic [16:0]             lfsr;

	int errY;
	int errValid;
	int errOther;
	int sentCount;
	int gotCount;

	sigmoid uut (
		.clk        (clk),
		.i_rstN     (i_rstN),
		.i_inValid  (i_inValid),
		.i_x        (i_x),
		.o_y        (o_y),
		.o_outValid (o_outValid)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// record what went into the pipeline on each edge
	always @(posedge clk) begin
		if (!i_rstN) begin
			validHist <= '0;
			resetDone <= 1'b1;
		end else begin
			validHist <= {validHist[`SIG_LATENCY-2:0], i_inValid};
		end
	end

	// outputs are stable mid-cycle, check them there
	always @(negedge clk) begin
		yData wantY;
		xData wantX;
		if (resetDone) begin
			checkValid(o_outValid, validHist[`SIG_LATENCY-1]);
			if (o_outValid === 1'b1) begin
				if (expY.size() == 0) begin
					$display("output valid at %0t with no input pending", $time);
					errOther++;
				end else begin
					wantY = expY.pop_front();
					wantX = expX.pop_front();
					checkY(o_y, wantY, wantX);
					gotCount++;
				end
			end
		end
	end

	task automatic checkY(input yData got, input yData want, input xData x);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: x=%0d gave y=%h, expected %h",
				$time, x, got, want);
			errY++;
		end
	endtask

	task automatic checkValid(input logic got, input logic want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t: o_outValid=%b, expected %b",
				$time, got, want);
			errValid++;
		end
	endtask

	// Fibonacci LFSR, taps at bits 17 and 14
	function automatic logic [16:0] lfsrNext(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic takeBit(output logic b);
		lfsr = lfsrNext(lfsr);
		b = lfsr[0];
	endtask

	// 0 to 3 idle cycles
	task automatic pickGap(output int gap);
		logic b0;
		logic b1;
		takeBit(b0);
		takeBit(b1);
		gap = 2 * int'(b1) + int'(b0);
	endtask

	// junk data while valid is low
	task automatic junkX(output xData x);
		logic b;
		for (int i = 0; i < `SIG_X_W; i++) begin
			takeBit(b);
			x[i] = b;
		end
	endtask

	task automatic driveIdle(input int n);
		xData junk;
		repeat (n) begin
			junkX(junk);
			@(negedge clk);
			i_inValid = 1'b0;
			i_x = junk;
		end
	endtask

	task automatic driveEntry(input int idx);
		@(negedge clk);
		i_inValid = 1'b1;
		i_x = xTab[idx];
		expY.push_back(yTab[idx]);
		expX.push_back(xTab[idx]);
		sentCount++;
	endtask

	// queue only changes on the falling edge
	task automatic waitDrain(output logic timedOut);
		int cycles;
		cycles = 0;
		timedOut = 1'b0;
		while (expY.size() != 0 && !timedOut) begin
			@(posedge clk);
			cycles++;
			if (cycles > drainLimit) begin
				timedOut = 1'b1;
			end
		end
	endtask

	initial begin
		int   gap;
		logic timedOut;
		i_rstN = 1'b0;
		i_inValid = 1'b0;
		i_x = '0;
		resetDone = 1'b0;
		lfsr = lfsrSeed;
		errY = 0;
		errValid = 0;
		errOther = 0;
		sentCount = 0;
		gotCount = 0;
		fillTable();

		// reset for 10 clocks
		repeat (10) begin
			@(negedge clk);
		end
		i_rstN = 1'b1;

		// quiet pipeline after reset
		driveIdle(10);

		// first pass with random gaps between entries
		for (int i = 0; i < numVectors; i++) begin
			pickGap(gap);
			driveIdle(gap);
			driveEntry(i);
		end
		driveIdle(1);

		// second pass back to back, one entry per clock
		for (int i = 0; i < numVectors; i++) begin
			driveEntry(i);
		end
		driveIdle(1);

		waitDrain(timedOut);
		if (timedOut) begin
			$display("timed out waiting for %0d results to leave the pipeline",
				expY.size());
			errOther++;
		end

		// watch for stray valid pulses once drained
		driveIdle(2 * `SIG_LATENCY);

		if (gotCount != sentCount) begin
			$display("sent %0d inputs but received %0d results", sentCount, gotCount);
			errOther++;
		end

		$display("errors: value %0d, valid %0d, other %0d", errY, errValid, errOther);
		if (errY + errValid + errOther == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sigmoidTypesPkg.sv */
`default_nettype none

`include "sigmoid_config.svh"

package sigmoidTypesPkg;

	// signed sample at the input
	typedef logic signed [`SIG_X_W-1:0] xData;

	// magnitude, bit 7 only set for the most negative input
	typedef logic [`SIG_X_W-1:0] absData;

	typedef logic [`SIG_SEG_W-1:0] segIdx;
	typedef logic [`SIG_FRAC_W-1:0] fracData;

	// coefficients
	typedef logic [`SIG_SLOPE_W-1:0] slopeVal;
	typedef logic [`SIG_ICPT_W-1:0] icptVal;

	// sum of two shifted partial products, needs two extra bits
	typedef logic [`SIG_FRAC_W+1:0] partSum;

	typedef logic [`SIG_PROD_W-1:0] prodVal;

	// encoded result word
	typedef logic [`SIG_Y_W-1:0] yData;

endpackage

`default_nettype wire

/* sigmoid_config.svh */
`ifndef SIGMOID_CONFIG_SVH
`define SIGMOID_CONFIG_SVH

// input and output word widths
`define SIG_X_W       8
`define SIG_Y_W       16

// segment select from magnitude bits 6..4
`define SIG_SEG_W     3
`define SIG_SEG_NUM   8

// magnitude bits 3..0 go into the multiply
`define SIG_FRAC_W    4

// coefficient and result widths
`define SIG_SLOPE_W   4
`define SIG_ICPT_W    10
`define SIG_PROD_W    8

// input strobe to output strobe, in clocks
`define SIG_LATENCY   6

`endif
